/* filelist.f */
source/jpq_pkg.sv
source/zig_zag_order.sv
source/coef_bank_ram.sv
source/quant_table_ram.sv
source/quant_sequencer.sv
source/pipelined_divider.sv
source/jpeg_quantizer.sv
bench/jpeg_quantizer_chk.sv
bench/tb_clock_gen.sv
bench/jpeg_quantizer_tb.sv

/* Bender.yml */
package:
  name: jpeg_quantizer

sources:
  - files:
      - source/jpq_pkg.sv
      - source/zig_zag_order.sv
      - source/coef_bank_ram.sv
      - source/quant_table_ram.sv
      - source/quant_sequencer.sv
      - source/pipelined_divider.sv
      - source/jpeg_quantizer.sv
  - target: simulation
    files:
      - bench/jpeg_quantizer_chk.sv
      - bench/tb_clock_gen.sv
      - bench/jpeg_quantizer_tb.sv

/* bench/jpeg_quantizer_tb.sv */
// jpeg quantizer testbench

`timescale 1ns/1ps

module jpeg_quantizer_tb;

    localparam int num_blocks = jpq_pkg::blocks_per_group;
    localparam int block_size = jpq_pkg::block_size;
    localparam int num_tests = 5;
    localparam logic [31:0] seed = 32'h05e3_0778;

    typedef enum int {QTAB_ONES, QTAB_RAMP, QTAB_RANDOM} qtab_mode_e;
    typedef enum int {COEF_RANDOM, COEF_EXTREME, COEF_ZERO} coef_mode_e;

    ///////////////////////////////////////////////////////////////////////
    // test table, one column per array
    string      test_name   [num_tests] = '{"identity", "ramp_random", "extremes",
                                            "back_to_back", "zeros"};
    int         test_groups [num_tests] = '{1, 1, 1, 3, 1};
    qtab_mode_e test_qtab   [num_tests] = '{QTAB_ONES, QTAB_RAMP, QTAB_RAMP,
                                            QTAB_RANDOM, QTAB_RAMP};
    coef_mode_e test_coef   [num_tests] = '{COEF_RANDOM, COEF_RANDOM, COEF_EXTREME,
                                            COEF_RANDOM, COEF_ZERO};

    logic                clock;
    logic                nreset;
    logic                coef_wr_valid;
    jpq_pkg::coef_wr_t   coef_wr;
    logic                qtab_wr_valid;
    jpq_pkg::qtab_wr_t   qtab_wr;
    logic                group_done;
    logic                quant_valid;
    jpq_pkg::quant_out_t quant;

    logic [31:0]         rng_state;
    int                  zz_to_rm [block_size];
    int                  qtab_model [block_size];
    int                  coef_model [jpq_pkg::num_groups][num_blocks][block_size];
    jpq_pkg::quant_out_t expected_q [$];
    string               current_test;
    int                  producer_slot;
    int                  mismatch_count;
    int                  other_count;

    tb_clock_gen #(
        .period_ns    (40),
        .reset_cycles (16)
    ) u_clock_gen (
        .clock_o  (clock),
        .nreset_o (nreset)
    );

    jpeg_quantizer #(
        .num_blocks (num_blocks)
    ) DUT (
        .clock           (clock),
        .nreset          (nreset),
        .coef_wr_valid_i (coef_wr_valid),
        .coef_wr_i       (coef_wr),
        .qtab_wr_valid_i (qtab_wr_valid),
        .qtab_wr_i       (qtab_wr),
        .group_done_i    (group_done),
        .quant_valid_o   (quant_valid),
        .quant_o         (quant)
    );

    function automatic logic [31:0] next_random(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // even diagonals run up and to the right, odd ones down and to the left
    task automatic build_zigzag_table();
        int pos;
        int row;
        int col;
        pos = 0;
        for (int s = 0; s < 15; s++) begin
            for (int k = 0; k < 8; k++) begin
                row = (s % 2 == 0) ? s - k : k;
                col = s - row;
                if (row >= 0 && row < 8 && col >= 0 && col < 8) begin
                    zz_to_rm[pos] = row * 8 + col;
                    pos++;
                end
            end
        end
    endtask

    task automatic load_quant_table(input qtab_mode_e mode);
        int value;
        for (int zz = 0; zz < block_size; zz++) begin
            if (mode == QTAB_ONES) begin
                value = 1;
            end else if (mode == QTAB_RAMP) begin
                value = zz + 1;
            end else begin
                rng_state = next_random(rng_state);
                value = int'(rng_state % 255) + 1;
            end
            qtab_model[zz] = value;
            @(negedge clock);
            qtab_wr_valid = 1'b1;
            qtab_wr.index = jpq_pkg::coef_idx_t'(zz);
            qtab_wr.value = jpq_pkg::qval_width'(value);
        end
        @(negedge clock);
        qtab_wr_valid = 1'b0;
    endtask

    // fills one slot in row-major order, block by block
    task automatic write_group(input int slot, input coef_mode_e mode);
        int value;
        for (int b = 0; b < num_blocks; b++) begin
            for (int i = 0; i < block_size; i++) begin
                rng_state = next_random(rng_state);
                if (mode == COEF_RANDOM) begin
                    value = int'($signed(rng_state[15:0]));
                end else if (mode == COEF_EXTREME) begin
                    value = (rng_state % 3 == 0) ? 32767 :
                            (rng_state % 3 == 1) ? -32767 : -32768;
                end else begin
                    value = 0;
                end
                coef_model[slot][b][i] = value;
                @(negedge clock);
                coef_wr_valid = 1'b1;
                coef_wr.group = jpq_pkg::group_idx_t'(slot);
                coef_wr.block = jpq_pkg::block_idx_t'(b);
                coef_wr.index = jpq_pkg::coef_idx_t'(i);
                coef_wr.coef = 16'(value);
            end
        end
        @(negedge clock);
        coef_wr_valid = 1'b0;
    endtask

    // results leave in zig-zag order, and the sv divide truncates toward zero
    task automatic push_expected(input int slot);
        jpq_pkg::quant_out_t r;
        for (int b = 0; b < num_blocks; b++) begin
            for (int zz = 0; zz < block_size; zz++) begin
                r.tag.group = jpq_pkg::group_idx_t'(slot);
                r.tag.block = jpq_pkg::block_idx_t'(b);
                r.tag.index = jpq_pkg::coef_idx_t'(zz);
                r.quotient = 16'(coef_model[slot][b][zz_to_rm[zz]] / qtab_model[zz]);
                expected_q.push_back(r);
            end
        end
    endtask

    task automatic pulse_groups(input int count);
        for (int g = 0; g < count; g++) begin
            @(negedge clock);
            group_done = 1'b1;
            push_expected(producer_slot);
            producer_slot = (producer_slot + 1) % jpq_pkg::num_groups;
        end
        @(negedge clock);
        group_done = 1'b0;
    endtask

    task automatic compare_value(input string what, input logic signed [31:0] expected,
                                 input logic signed [31:0] actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("ERR %s: expected %0d, actual %0d", what, expected, actual);
        end
    endtask

    task automatic check_result(input jpq_pkg::quant_out_t actual);
        jpq_pkg::quant_out_t expected;
        string what;
        if (expected_q.size() == 0) begin
            other_count++;
            $display("%s: the DUT produced a result while none was pending", current_test);
        end else begin
            expected = expected_q.pop_front();
            what = $sformatf("%s g%0d b%0d zz%0d", current_test, expected.tag.group,
                             expected.tag.block, expected.tag.index);
            compare_value({what, " tag"}, 32'(expected.tag), 32'(actual.tag));
            compare_value({what, " quotient"}, 32'(expected.quotient), 32'(actual.quotient));
        end
    endtask

    // outputs change on the rising edge, so they are read on the falling one
    always @(negedge clock) begin
        if (!nreset && quant_valid === 1'b1) begin
            check_result(quant);
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // main sequence
    initial begin
        coef_wr_valid = 1'b0;
        coef_wr = '0;
        qtab_wr_valid = 1'b0;
        qtab_wr = '0;
        group_done = 1'b0;
        rng_state = seed;
        producer_slot = 0;
        mismatch_count = 0;
        other_count = 0;
        current_test = "reset";
        build_zigzag_table();
        wait (nreset == 1'b0);
        @(negedge clock);
        for (int t = 0; t < num_tests; t++) begin
            current_test = test_name[t];
            // the table changes only while the quantizer is idle
            load_quant_table(test_qtab[t]);
            for (int g = 0; g < test_groups[t]; g++) begin
                write_group((producer_slot + g) % jpq_pkg::num_groups, test_coef[t]);
            end
            pulse_groups(test_groups[t]);
            while (expected_q.size() != 0) begin
                @(negedge clock);
            end
            // a quiet gap shows any result beyond the expected count
            repeat (24) @(negedge clock);
        end
        $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 mismatch_count, other_count, DUT.u_chk.failures);
        if (mismatch_count == 0 && other_count == 0 && DUT.u_chk.failures == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // a group costs about 700 cycles of writes and quantizing, 800 leaves a margin
    initial begin : watchdog
        int limit;
        limit = 2000;
        for (int t = 0; t < num_tests; t++) begin
            limit += test_groups[t] * 800;
        end
        repeat (limit) @(posedge clock);
        other_count++;
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 mismatch_count, other_count, DUT.u_chk.failures);
        $display("test failed");
        $finish;
    end

endmodule

/* bench/tb_clock_gen.sv */
// testbench clock and reset

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 16
) (
    output logic clock_o,
    output logic nreset_o
);

    initial begin
        clock_o = 1'b0;
        forever #(period_ns / 2) clock_o = ~clock_o;
    end

    // reset is active high and drops on a falling edge, away from the sampling edge
    initial begin
        nreset_o = 1'b1;
        repeat (reset_cycles) @(posedge clock_o);
        @(negedge clock_o);
        nreset_o = 1'b0;
    end

endmodule

/* bench/jpeg_quantizer_chk.sv */
// quantizer output assertions

`timescale 1ns/1ps

module jpeg_quantizer_chk (
    input logic                clock,
    input logic                nreset,
    input logic                group_done_i,
    input logic                seq_idle_i,
    input logic                quant_valid_i,
    input jpq_pkg::quant_out_t quant_i
);

    // the pulse is counted on its edge, the walk starts one edge later,
    // and the first result rises 18 edges after that
    localparam int start_latency = 20;

    int failures = 0;

    valid_low_in_reset: assert property (
        @(posedge clock) nreset ##1 nreset |-> !quant_valid_i
    ) else begin
        failures++;
        $error("quant_valid_o was high during reset");
    end

    // indices wrap from 63 to 0 at each block boundary
    index_steps: assert property (
        @(posedge clock) disable iff (nreset)
        quant_valid_i && $past(quant_valid_i) |->
            quant_i.tag.index == jpq_pkg::coef_idx_t'($past(quant_i.tag.index) + 1'b1)
    ) else begin
        failures++;
        $error("zig-zag index did not advance by one between results");
    end

    first_result_latency: assert property (
        @(posedge clock) disable iff (nreset)
        group_done_i && seq_idle_i |-> ##start_latency quant_valid_i
    ) else begin
        failures++;
        $error("no result at the fixed latency after a group started");
    end

endmodule

bind jpeg_quantizer jpeg_quantizer_chk u_chk (
    .clock         (clock),
    .nreset        (nreset),
    .group_done_i  (group_done_i),
    .seq_idle_i    (u_sequencer.state == jpq_pkg::WAIT &&
                    u_sequencer.read_slot == u_sequencer.written_count),
    .quant_valid_i (quant_valid_o),
    .quant_i       (quant_o)
);

/* source/jpeg_quantizer.sv */
// jpeg quantizer top level

`timescale 1ns/1ps

module jpeg_quantizer #(
    parameter int num_blocks = jpq_pkg::blocks_per_group
) (
    input  logic                 clock,
    input  logic                 nreset,
    input  logic                 coef_wr_valid_i,
    input  jpq_pkg::coef_wr_t    coef_wr_i,
    input  logic                 qtab_wr_valid_i,
    input  jpq_pkg::qtab_wr_t    qtab_wr_i,
    input  logic                 group_done_i,
    output logic                 quant_valid_o,
    output jpq_pkg::quant_out_t  quant_o
);

    jpq_pkg::group_idx_t coef_group;
    jpq_pkg::block_idx_t coef_block;
    jpq_pkg::coef_idx_t  coef_index;
    jpq_pkg::coef_idx_t  qtab_index;
    logic                req_valid;
    jpq_pkg::quant_tag_t req_tag;
    logic signed [jpq_pkg::coef_width-1:0] coef_rd_data;
    logic [jpq_pkg::qval_width-1:0]        qtab_rd_data;

    ///////////////////////////////////////////////////////////////////////
    // memories
    coef_bank_ram #(
        .num_blocks (num_blocks)
    ) u_coef_bank (
        .clock      (clock),
        .wr_valid_i (coef_wr_valid_i),
        .wr_i       (coef_wr_i),
        .rd_group_i (coef_group),
        .rd_block_i (coef_block),
        .rd_index_i (coef_index),
        .rd_data_o  (coef_rd_data)
    );

    quant_table_ram u_quant_table (
        .clock      (clock),
        .wr_valid_i (qtab_wr_valid_i),
        .wr_i       (qtab_wr_i),
        .rd_index_i (qtab_index),
        .rd_data_o  (qtab_rd_data)
    );

    ///////////////////////////////////////////////////////////////////////
    // sequencing and division
    quant_sequencer #(
        .num_blocks (num_blocks)
    ) u_sequencer (
        .clock        (clock),
        .nreset       (nreset),
        .group_done_i (group_done_i),
        .coef_group_o (coef_group),
        .coef_block_o (coef_block),
        .coef_index_o (coef_index),
        .qtab_index_o (qtab_index),
        .req_valid_o  (req_valid),
        .req_tag_o    (req_tag)
    );

    pipelined_divider u_divider (
        .clock      (clock),
        .nreset     (nreset),
        .valid_i    (req_valid),
        .dividend_i (coef_rd_data),
        .divisor_i  (qtab_rd_data),
        .tag_i      (req_tag),
        .valid_o    (quant_valid_o),
        .result_o   (quant_o)
    );

endmodule

/* source/pipelined_divider.sv */
// pipelined restoring divider

`timescale 1ns/1ps

module pipelined_divider (
    input  logic                                  clock,
    input  logic                                  nreset,
    input  logic                                  valid_i,
    input  logic signed [jpq_pkg::coef_width-1:0] dividend_i,
    input  logic [jpq_pkg::qval_width-1:0]        divisor_i,
    input  jpq_pkg::quant_tag_t                   tag_i,
    output logic                                  valid_o,
    output jpq_pkg::quant_out_t                   result_o
);

    localparam int stages = jpq_pkg::coef_width;

    // work starts as the dividend magnitude and fills with quotient bits from the right
    typedef struct packed {
        logic [jpq_pkg::qval_width-1:0]  rem;
        logic [jpq_pkg::coef_width-1:0]  work;
        logic [jpq_pkg::qval_width-1:0]  divisor;
        logic                            neg;
        jpq_pkg::quant_tag_t             tag;
    } stage_t;

    stage_t              head;
    stage_t              stage_q [stages];
    logic [stages-1:0]   valid_q;
    logic [jpq_pkg::coef_width-1:0] magnitude;

    // one quotient bit, the remainder stays below the divisor so it fits in 8 bits
    function automatic stage_t div_step(input stage_t cur);
        stage_t nxt;
        logic [jpq_pkg::qval_width:0] trial;
        logic [jpq_pkg::qval_width:0] diff;
        nxt = cur;
        trial = {cur.rem, cur.work[jpq_pkg::coef_width-1]};
        diff = trial - {1'b0, cur.divisor};
        if (trial >= {1'b0, cur.divisor}) begin
            nxt.rem = diff[jpq_pkg::qval_width-1:0];
            nxt.work = {cur.work[jpq_pkg::coef_width-2:0], 1'b1};
        end else begin
            nxt.rem = trial[jpq_pkg::qval_width-1:0];
            nxt.work = {cur.work[jpq_pkg::coef_width-2:0], 1'b0};
        end
        return nxt;
    endfunction

    // -32768 negates to 16'h8000, which is the right magnitude when read unsigned
    assign magnitude = dividend_i[jpq_pkg::coef_width-1] ? -dividend_i : dividend_i;

    always_comb begin
        head.rem = '0;
        head.work = magnitude;
        head.divisor = divisor_i;
        head.neg = dividend_i[jpq_pkg::coef_width-1];
        head.tag = tag_i;
    end

    ///////////////////////////////////////////////////////////////////////
    // stages
    always_ff @(posedge clock) begin
        stage_q[0] <= div_step(head);
        for (int k = 1; k < stages; k++) begin
            stage_q[k] <= div_step(stage_q[k-1]);
        end
    end

    always_ff @(posedge clock) begin
        if (nreset) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[stages-2:0], valid_i};
        end
    end

    // restoring the sign afterwards truncates toward zero
    assign valid_o = valid_q[stages-1];
    assign result_o.tag = stage_q[stages-1].tag;
    assign result_o.quotient = stage_q[stages-1].neg ? -stage_q[stages-1].work
                                                     : stage_q[stages-1].work;

endmodule

/* source/quant_sequencer.sv */
// quantizer read sequencer

`timescale 1ns/1ps

module quant_sequencer #(
    parameter int num_blocks = jpq_pkg::blocks_per_group
) (
    input  logic                 clock,
    input  logic                 nreset,
    input  logic                 group_done_i,
    output jpq_pkg::group_idx_t  coef_group_o,
    output jpq_pkg::block_idx_t  coef_block_o,
    output jpq_pkg::coef_idx_t   coef_index_o,
    output jpq_pkg::coef_idx_t   qtab_index_o,
    output logic                 req_valid_o,
    output jpq_pkg::quant_tag_t  req_tag_o
);

    localparam jpq_pkg::block_idx_t last_block = jpq_pkg::block_idx_t'(num_blocks - 1);
    localparam jpq_pkg::coef_idx_t last_index = jpq_pkg::coef_idx_t'(jpq_pkg::block_size - 1);

    jpq_pkg::quant_state_e state;
    jpq_pkg::group_idx_t   written_count;
    jpq_pkg::group_idx_t   read_slot;
    jpq_pkg::block_idx_t   block_cnt;
    jpq_pkg::coef_idx_t    zz_cnt;
    jpq_pkg::coef_idx_t    rm_index;
    logic                  addr_valid;
    jpq_pkg::quant_tag_t   addr_tag;

    // the producer finishes slots in order, so a counter tracks the newest one
    always_ff @(posedge clock) begin
        if (nreset) begin
            written_count <= '0;
        end else if (group_done_i) begin
            written_count <= written_count + 1'b1;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // group walk
    always_ff @(posedge clock) begin
        if (nreset) begin
            state <= jpq_pkg::WAIT;
            read_slot <= '0;
            block_cnt <= '0;
            zz_cnt <= '0;
        end else begin
            case (state)
                jpq_pkg::WAIT: begin
                    block_cnt <= '0;
                    zz_cnt <= '0;
                    if (read_slot != written_count) begin
                        state <= jpq_pkg::QUANTIZE;
                    end
                end

                jpq_pkg::QUANTIZE: begin
                    // the zig-zag counter wraps to 0 on its own after position 63
                    zz_cnt <= zz_cnt + 1'b1;
                    if (zz_cnt == last_index) begin
                        if (block_cnt == last_block) begin
                            block_cnt <= '0;
                            read_slot <= read_slot + 1'b1;
                            state <= jpq_pkg::WAIT;
                        end else begin
                            block_cnt <= block_cnt + 1'b1;
                        end
                    end
                end

                default: begin
                    state <= jpq_pkg::WAIT;
                end
            endcase
        end
    end

    zig_zag_order u_zig_zag (
        .zz_index_i        (zz_cnt),
        .row_major_index_o (rm_index)
    );

    ///////////////////////////////////////////////////////////////////////
    // address and request registers

    // addresses leave registered, the strobe follows one cycle later with the read data
    always_ff @(posedge clock) begin
        coef_group_o <= read_slot;
        coef_block_o <= block_cnt;
        coef_index_o <= rm_index;
        qtab_index_o <= zz_cnt;
        addr_tag.group <= read_slot;
        addr_tag.block <= block_cnt;
        addr_tag.index <= zz_cnt;
        req_tag_o <= addr_tag;
    end

    always_ff @(posedge clock) begin
        if (nreset) begin
            addr_valid <= 1'b0;
            req_valid_o <= 1'b0;
        end else begin
            addr_valid <= (state == jpq_pkg::QUANTIZE);
            req_valid_o <= addr_valid;
        end
    end

endmodule

/* source/quant_table_ram.sv */
// quantization table memory

`timescale 1ns/1ps

module quant_table_ram (
    input  logic                             clock,
    input  logic                             wr_valid_i,
    input  jpq_pkg::qtab_wr_t                wr_i,
    input  jpq_pkg::coef_idx_t               rd_index_i,
    output logic [jpq_pkg::qval_width-1:0]   rd_data_o
);

    // one divisor per zig-zag position
    logic [jpq_pkg::qval_width-1:0] mem [jpq_pkg::block_size];

    always_ff @(posedge clock) begin
        if (wr_valid_i) begin
            mem[wr_i.index] <= wr_i.value;
        end
        rd_data_o <= mem[rd_index_i];
    end

endmodule

/* source/coef_bank_ram.sv */
// coefficient bank memory

`timescale 1ns/1ps

module coef_bank_ram #(
    parameter int num_blocks = jpq_pkg::blocks_per_group
) (
    input  logic                                 clock,
    input  logic                                 wr_valid_i,
    input  jpq_pkg::coef_wr_t                    wr_i,
    input  jpq_pkg::group_idx_t                  rd_group_i,
    input  jpq_pkg::block_idx_t                  rd_block_i,
    input  jpq_pkg::coef_idx_t                   rd_index_i,
    output logic signed [jpq_pkg::coef_width-1:0] rd_data_o
);

    localparam int depth = jpq_pkg::num_groups * num_blocks * jpq_pkg::block_size;
    localparam int addr_width = $clog2(depth);

    logic signed [jpq_pkg::coef_width-1:0] mem [depth];
    logic [addr_width-1:0] wr_addr;
    logic [addr_width-1:0] rd_addr;

    // groups are laid out back to back, each one holding its blocks in order
    function automatic logic [addr_width-1:0] bank_addr(
        input jpq_pkg::group_idx_t group,
        input jpq_pkg::block_idx_t block,
        input jpq_pkg::coef_idx_t  index
    );
        int flat;
        flat = (int'(group) * num_blocks + int'(block)) * jpq_pkg::block_size + int'(index);
        return addr_width'(flat);
    endfunction

    assign wr_addr = bank_addr(wr_i.group, wr_i.block, wr_i.index);
    assign rd_addr = bank_addr(rd_group_i, rd_block_i, rd_index_i);

    always_ff @(posedge clock) begin
        if (wr_valid_i) begin
            mem[wr_addr] <= wr_i.coef;
        end
        rd_data_o <= mem[rd_addr];
    end

endmodule

/* source/zig_zag_order.sv */
// zig-zag scan lookup

`timescale 1ns/1ps

module zig_zag_order (
    input  jpq_pkg::coef_idx_t zz_index_i,
    output jpq_pkg::coef_idx_t row_major_index_o
);

    // standard jpeg scan, position along the zig-zag path to row * 8 + column
    always_comb begin
        case (zz_index_i)
            6'd0:  row_major_index_o = 6'd0;
            6'd1:  row_major_index_o = 6'd1;
            6'd2:  row_major_index_o = 6'd8;
            6'd3:  row_major_index_o = 6'd16;
            6'd4:  row_major_index_o = 6'd9;
            6'd5:  row_major_index_o = 6'd2;
            6'd6:  row_major_index_o = 6'd3;
            6'd7:  row_major_index_o = 6'd10;
            6'd8:  row_major_index_o = 6'd17;
            6'd9:  row_major_index_o = 6'd24;
            6'd10: row_major_index_o = 6'd32;
            6'd11: row_major_index_o = 6'd25;
            6'd12: row_major_index_o = 6'd18;
            6'd13: row_major_index_o = 6'd11;
            6'd14: row_major_index_o = 6'd4;
            6'd15: row_major_index_o = 6'd5;
            6'd16: row_major_index_o = 6'd12;
            6'd17: row_major_index_o = 6'd19;
            6'd18: row_major_index_o = 6'd26;
            6'd19: row_major_index_o = 6'd33;
            6'd20: row_major_index_o = 6'd40;
            6'd21: row_major_index_o = 6'd48;
            6'd22: row_major_index_o = 6'd41;
            6'd23: row_major_index_o = 6'd34;
            6'd24: row_major_index_o = 6'd27;
            6'd25: row_major_index_o = 6'd20;
            6'd26: row_major_index_o = 6'd13;
            6'd27: row_major_index_o = 6'd6;
            6'd28: row_major_index_o = 6'd7;
            6'd29: row_major_index_o = 6'd14;
            6'd30: row_major_index_o = 6'd21;
            6'd31: row_major_index_o = 6'd28;
            6'd32: row_major_index_o = 6'd35;
            6'd33: row_major_index_o = 6'd42;
            6'd34: row_major_index_o = 6'd49;
            6'd35: row_major_index_o = 6'd56;
            6'd36: row_major_index_o = 6'd57;
            6'd37: row_major_index_o = 6'd50;
            6'd38: row_major_index_o = 6'd43;
            6'd39: row_major_index_o = 6'd36;
            6'd40: row_major_index_o = 6'd29;
            6'd41: row_major_index_o = 6'd22;
            6'd42: row_major_index_o = 6'd15;
            6'd43: row_major_index_o = 6'd23;
            6'd44: row_major_index_o = 6'd30;
            6'd45: row_major_index_o = 6'd37;
            6'd46: row_major_index_o = 6'd44;
            6'd47: row_major_index_o = 6'd51;
            6'd48: row_major_index_o = 6'd58;
            6'd49: row_major_index_o = 6'd59;
            6'd50: row_major_index_o = 6'd52;
            6'd51: row_major_index_o = 6'd45;
            6'd52: row_major_index_o = 6'd38;
            6'd53: row_major_index_o = 6'd31;
            6'd54: row_major_index_o = 6'd39;
            6'd55: row_major_index_o = 6'd46;
            6'd56: row_major_index_o = 6'd53;
            6'd57: row_major_index_o = 6'd60;
            6'd58: row_major_index_o = 6'd61;
            6'd59: row_major_index_o = 6'd54;
            6'd60: row_major_index_o = 6'd47;
            6'd61: row_major_index_o = 6'd55;
            6'd62: row_major_index_o = 6'd62;
            6'd63: row_major_index_o = 6'd63;
        endcase
    end

endmodule

/* source/jpq_pkg.sv */
// jpeg quantizer shared types

package jpq_pkg;

    ///////////////////////////////////////////////////////////////////////
    // geometry
    localparam int coef_width = 16;
    localparam int qval_width = 8;
    localparam int block_size = 64;
    localparam int blocks_per_group = 5;
    localparam int num_groups = 4;

    typedef logic [5:0] coef_idx_t;
    typedef logic [2:0] block_idx_t;

    // group slots wrap from 3 back to 0
    typedef logic [1:0] group_idx_t;

    typedef enum logic {
        WAIT     = 1'b0,
        QUANTIZE = 1'b1
    } quant_state_e;

    ///////////////////////////////////////////////////////////////////////
    // bundles

    // the index is row-major within the block
    typedef struct packed {
        group_idx_t                    group;
        block_idx_t                    block;
        coef_idx_t                     index;
        logic signed [coef_width-1:0]  coef;
    } coef_wr_t;

    // the index is a zig-zag position
    typedef struct packed {
        coef_idx_t                     index;
        logic [qval_width-1:0]         value;
    } qtab_wr_t;

    typedef struct packed {
        group_idx_t                    group;
        block_idx_t                    block;
        coef_idx_t                     index;
    } quant_tag_t;

    typedef struct packed {
        quant_tag_t                    tag;
        logic signed [coef_width-1:0]  quotient;
    } quant_out_t;

endpackage
